//--- sim.f
+incdir+.
m2v_cmd_pkg.sv
m2v_stage_pkg.sv
m2v_cmd_decode.sv
m2v_host_regs.sv
m2v_mb_addr.sv
m2v_side_info.sv
m2v_ctrl.sv
tb_m2v_checker.sv
tb_m2v_ctrl.sv

//--- Makefile
# Verilator build and run for the MPEG-2 decode controller

VERILATOR  ?= verilator
FLAGS      ?= --timing
TOP        ?= tb_m2v_ctrl
RTL_TOP    ?= m2v_ctrl
FILE_LIST  ?= sim.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- m2v_stimulus.txt
# C sel data | W addr data | R addr word irq | M col row busy_cycles
# P qm pict mvh mvv blkv start end picture | V qm_value {custom,intra} s0_data qscode
R 0 00000000 0
R 1 00000000 0
W 0 00000000
C 001 0010
C 001 0010
R 0 02000030 1
W 0 00000010
R 0 02000020 0
C 001 0018
R 0 03000038 1
W 0 00000010
R 0 03000028 1
W 0 00000088
R 0 00000020 0
W 0 00000020
C 001 0040
R 0 00000040 0
W 0 00000040
R 0 00000000 0
C 002 2140
R 1 00000140 0
C 002 40F0
R 1 00F00140 0
C 002 8003
R 1 30F00140 0
C 002 E005
R 1 50050005 0
C 003 0403
C 005 0002
M 3 2 0
C 007 0001
M 0 3 2
C 007 0002
C 007 000C
M 2 6 5
C 007 0001
M 3 6 1
C 004 0312
C 006 0029
C 006 0007
C 006 0040
C 110 1234
C 120 00AB
C 140 00CD
C 180 0F0F
C 004 0155
V 55 1 0F0F 09
C 006 0035
C 006 0040
V 55 1 0F0F 15
C 001 0001
C 001 0004
C 001 0005
P 2 1 1 1 1 2 2 3

//--- tb_m2v_ctrl.sv
// Testbench for the MPEG-2 decode controller
// Reads commands, host accesses and expectations from the stimulus file

module tb_m2v_ctrl;

	logic                       clk = 1'b0;
	logic                       reset_n;
	logic                       cmd_valid;
	m2v_cmd_pkg::cmd_sel_t      cmd_sel;
	m2v_cmd_pkg::cmd_data_t     cmd_data;
	logic                       cmd_ready;
	logic                       control_address;
	logic                       control_read;
	logic                       control_write;
	m2v_stage_pkg::host_word_t  control_writedata;
	m2v_stage_pkg::host_word_t  control_readdata;
	logic                       control_readdatavalid;
	logic                       irq;
	logic [15:0]                s0_data;
	logic                       pict_valid;
	logic                       mvec_h_valid;
	logic                       mvec_v_valid;
	logic                       s0_valid;
	m2v_stage_pkg::mb_x_t       s0_mb_x;
	m2v_stage_pkg::mb_y_t       s0_mb_y;
	m2v_stage_pkg::qscode_t     s0_mb_qscode;
	logic                       qm_valid;
	logic                       qm_custom;
	logic                       qm_intra;
	logic [7:0]                 qm_value;
	logic                       softreset;
	logic                       pre_block_start;
	logic                       block_start;
	logic                       block_end;
	logic                       picture_complete;

	// Expectation handoff to the checker
	logic                       chk_req;
	logic [1:0]                 chk_kind;
	logic [31:0]                exp_a;
	logic [31:0]                exp_b;
	logic [31:0]                exp_c;
	logic [31:0]                exp_d;
	logic [63:0]                exp_counts;
	int                         check_errors;

	int                         cycle_count = 0;
	int                         cycle_limit = 100000;
	int                         stim_errors = 0;
	logic [15:0]                lfsr = 16'd48107;

	always #50 clk = ~clk;

	m2v_ctrl u_dut (.*);

	tb_m2v_checker u_chk (.*, .error_count(check_errors));

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	//------------------------------------------------------------
	// Driver tasks entered and left on a falling edge
	//------------------------------------------------------------
	task automatic idle_gap();
		logic [1:0] n;
		lfsr = lfsr_next(lfsr);
		n[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		n[1] = lfsr[0];
		repeat (n) @(negedge clk);
	endtask

	task automatic send_command(input logic [8:0] sel, input logic [15:0] data);
		cmd_valid = 1'b1;
		cmd_sel   = sel;
		cmd_data  = data;
		while (!cmd_ready)
			@(negedge clk);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// Lets the last command reach every output
	task automatic wait_settled();
		while (!cmd_ready)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	task automatic host_write(input logic addr, input logic [31:0] data);
		control_address   = addr;
		control_writedata = data;
		control_write     = 1'b1;
		@(negedge clk);
		control_write = 1'b0;
	endtask

	task automatic host_read(input logic addr, input logic [31:0] word, input logic exp_irq);
		wait_settled();
		control_address = addr;
		exp_a           = word;
		exp_b           = {31'd0, exp_irq};
		control_read    = 1'b1;
		@(negedge clk);
		control_read = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic request_check(input logic [1:0] kind);
		wait_settled();
		chk_kind = kind;
		chk_req  = 1'b1;
		@(negedge clk);
		chk_req = 1'b0;
	endtask

	// One pass over the stimulus file, line by line
	task automatic play_stimulus();
		int          fd;
		int          code;
		byte         kind;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic        done;

		done = 1'b0;
		fd   = $fopen("m2v_stimulus.txt", "r");
		while (!done) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;
			end else begin
				case (kind)
					"#": code = $fgets(line, fd);
					"C": begin
						code = $fscanf(fd, "%h %h", a, b);
						send_command(a[8:0], b[15:0]);
						idle_gap();
					end
					"W": begin
						code = $fscanf(fd, "%h %h", a, b);
						wait_settled();
						host_write(a[0], b);
					end
					"R": begin
						code = $fscanf(fd, "%h %h %h", a, b, c);
						host_read(a[0], b, c[0]);
					end
					"M": begin
						code  = $fscanf(fd, "%h %h %h", exp_a, exp_b, exp_c);
						request_check(2'd1);
					end
					"P": begin
						for (int i = 0; i < 8; i++) begin
							code = $fscanf(fd, "%h", a);
							exp_counts[63 - 8 * i -: 8] = a[7:0];
						end
						request_check(2'd2);
					end
					"V": begin
						code = $fscanf(fd, "%h %h %h %h", exp_a, exp_b, exp_c, exp_d);
						request_check(2'd3);
					end
					default: begin
						$display("Unknown stimulus line kind '%c'", kind);
						stim_errors++;
						code = $fgets(line, fd);
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int          fd;
		int          line_count;
		string       line;

		reset_n           = 1'b0;
		cmd_valid         = 1'b0;
		cmd_sel           = '0;
		cmd_data          = '0;
		control_address   = 1'b0;
		control_read      = 1'b0;
		control_write     = 1'b0;
		control_writedata = '0;
		chk_req           = 1'b0;
		chk_kind          = '0;
		exp_a             = '0;
		exp_b             = '0;
		exp_c             = '0;
		exp_d             = '0;
		exp_counts        = '0;
		line_count        = 0;

		fd = $fopen("m2v_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file m2v_stimulus.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0)
					line_count++;
			end
			$fclose(fd);
			cycle_limit = line_count * 40;

			repeat (5) @(posedge clk);
			@(negedge clk);
			reset_n = 1'b1;
			@(negedge clk);

			play_stimulus();

			wait_settled();
			$display("Errors: %0d check mismatches, %0d stimulus problems",
				check_errors, stim_errors);
			if (check_errors == 0 && stim_errors == 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule

//--- tb_m2v_checker.sv
// Testbench checker for the decode controller
// Counts the stage strobes and compares reads and expectations with the ports

module tb_m2v_checker (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      cmd_ready,
	input  logic                      control_address,
	input  logic                      control_read,
	input  logic                      control_write,
	input  m2v_stage_pkg::host_word_t control_writedata,
	input  logic                      control_readdatavalid,
	input  m2v_stage_pkg::host_word_t control_readdata,
	input  logic                      irq,
	input  logic                      softreset,
	input  m2v_stage_pkg::mb_x_t      s0_mb_x,
	input  m2v_stage_pkg::mb_y_t      s0_mb_y,
	input  m2v_stage_pkg::qscode_t    s0_mb_qscode,
	input  logic [15:0]               s0_data,
	input  logic                      qm_valid,
	input  logic                      qm_intra,
	input  logic                      qm_custom,
	input  logic [7:0]                qm_value,
	input  logic                      pict_valid,
	input  logic                      mvec_h_valid,
	input  logic                      mvec_v_valid,
	input  logic                      s0_valid,
	input  logic                      pre_block_start,
	input  logic                      block_start,
	input  logic                      block_end,
	input  logic                      picture_complete,
	input  logic                      chk_req,
	input  logic [1:0]                chk_kind,
	input  logic [31:0]               exp_a,
	input  logic [31:0]               exp_b,
	input  logic [31:0]               exp_c,
	input  logic [31:0]               exp_d,
	input  logic [63:0]               exp_counts,
	output int                        error_count
);

	int          errors = 0;
	logic [63:0] pulse_counts;
	logic [31:0] busy_cycles;
	logic [31:0] pend_word;
	logic        pend_irq;
	logic        pre_q;
	logic        read_q;
	logic        exp_softreset;

	assign error_count = errors;

	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] expected);
		$display("** Error @%0t: %s is %0h, expected %0h", $time, what, got, expected);
		errors = errors + 1;
	endtask

	//------------------------------------------------------------
	// Strobe counters, busy cycles and pending read
	//------------------------------------------------------------
	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pulse_counts  <= '0;
			busy_cycles   <= '0;
			pre_q         <= 1'b0;
			read_q        <= 1'b0;
			exp_softreset <= 1'b1;
		end else begin
			// Field order as on the P line, qm first and picture last
			pulse_counts <= pulse_counts + {7'd0, qm_valid, 7'd0, pict_valid,
				7'd0, mvec_h_valid, 7'd0, mvec_v_valid, 7'd0, s0_valid,
				7'd0, block_start, 7'd0, block_end, 7'd0, picture_complete};
			if (chk_req && chk_kind == 2'd1)
				busy_cycles <= '0;
			else if (!cmd_ready)
				busy_cycles <= busy_cycles + 1;
			pre_q  <= pre_block_start;
			read_q <= control_read;
			// Status write loads soft reset from bit 7
			if (control_write && !control_address)
				exp_softreset <= control_writedata[7];
			if (control_read) begin
				pend_word <= exp_a;
				pend_irq  <= exp_b[0];
			end
		end
	end

	//------------------------------------------------------------
	// Comparisons
	//------------------------------------------------------------
	always @(posedge clk) begin
		if (reset_n) begin
			if (block_start !== pre_q)
				report_mismatch("block_start after pre_block_start", block_start, pre_q);
			if (control_readdatavalid !== read_q)
				report_mismatch("control_readdatavalid", control_readdatavalid, read_q);
			if (softreset !== exp_softreset)
				report_mismatch("softreset", softreset, exp_softreset);
			if (control_readdatavalid) begin
				if (control_readdata !== pend_word)
					report_mismatch("control_readdata", control_readdata, pend_word);
				if (irq !== pend_irq)
					report_mismatch("irq", irq, pend_irq);
			end
			if (chk_req) begin
				case (chk_kind)
					2'd1: begin
						if (s0_mb_x !== exp_a[5:0])
							report_mismatch("s0_mb_x", s0_mb_x, exp_a);
						if (s0_mb_y !== exp_b[4:0])
							report_mismatch("s0_mb_y", s0_mb_y, exp_b);
						if (busy_cycles !== exp_c)
							report_mismatch("cmd_ready low cycles", busy_cycles, exp_c);
					end
					2'd2: begin
						if (pulse_counts !== exp_counts)
							report_mismatch("pulse counts", pulse_counts, exp_counts);
					end
					2'd3: begin
						if (qm_value !== exp_a[7:0])
							report_mismatch("qm_value", qm_value, exp_a);
						if ({qm_custom, qm_intra} !== exp_b[1:0])
							report_mismatch("qm custom and intra", {qm_custom, qm_intra}, exp_b);
						if (s0_data !== exp_c[15:0])
							report_mismatch("s0_data", s0_data, exp_c);
						if (s0_mb_qscode !== exp_d[4:0])
							report_mismatch("s0_mb_qscode", s0_mb_qscode, exp_d);
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- m2v_ctrl.sv
// MPEG-2 video decode controller
// Sequencer command port and host register port driving the decode stages

`include "m2v_cfg.svh"

module m2v_ctrl (
	input  logic                            clk,
	input  logic                            reset_n,

	// Command port
	input  logic                            cmd_valid,
	input  logic [`M2V_CMD_SEL_WIDTH-1:0]   cmd_sel,
	input  logic [`M2V_CMD_DATA_WIDTH-1:0]  cmd_data,
	output logic                            cmd_ready,

	// Host port
	input  logic                            control_address,
	input  logic                            control_read,
	input  logic                            control_write,
	input  m2v_stage_pkg::host_word_t       control_writedata,
	output m2v_stage_pkg::host_word_t       control_readdata,
	output logic                            control_readdatavalid,
	output logic                            irq,

	// Side stage
	output logic [`M2V_CMD_DATA_WIDTH-1:0]  s0_data,
	output logic                            pict_valid,
	output logic                            mvec_h_valid,
	output logic                            mvec_v_valid,
	output logic                            s0_valid,
	output m2v_stage_pkg::mb_x_t            s0_mb_x,
	output m2v_stage_pkg::mb_y_t            s0_mb_y,
	output m2v_stage_pkg::qscode_t          s0_mb_qscode,

	// Inverse quantiser
	output logic                            qm_valid,
	output logic                            qm_custom,
	output logic                            qm_intra,
	output logic [7:0]                      qm_value,

	// All stages
	output logic                            softreset,
	output logic                            pre_block_start,
	output logic                            block_start,
	output logic                            block_end,
	output logic                            picture_complete
);

	// io_strobe bit n is I/O address n+1
	logic [6:0]                     io_strobe;
	logic [3:0]                     side_strobe;
	logic [`M2V_CMD_DATA_WIDTH-1:0] cmd_data_q;
	logic                           mb_busy;

	m2v_cmd_decode u_decode (
		.clk         (clk),
		.reset_n     (reset_n),
		.cmd_valid   (cmd_valid),
		.cmd_sel     (cmd_sel),
		.cmd_data    (cmd_data),
		.mb_busy     (mb_busy),
		.cmd_ready   (cmd_ready),
		.io_strobe   (io_strobe),
		.side_strobe (side_strobe),
		.cmd_data_q  (cmd_data_q)
	);

	m2v_host_regs u_host (
		.clk                   (clk),
		.reset_n               (reset_n),
		.control_address       (control_address),
		.control_read          (control_read),
		.control_write         (control_write),
		.control_writedata     (control_writedata),
		.ctrl_en               (io_strobe[0]),
		.video_en              (io_strobe[1]),
		.cmd_data_q            (cmd_data_q),
		.control_readdata      (control_readdata),
		.control_readdatavalid (control_readdatavalid),
		.irq                   (irq),
		.softreset             (softreset),
		.pre_block_start       (pre_block_start),
		.block_start           (block_start),
		.block_end             (block_end),
		.picture_complete      (picture_complete)
	);

	m2v_mb_addr u_mb_addr (
		.clk        (clk),
		.reset_n    (reset_n),
		.max_en     (io_strobe[2]),
		.slice_en   (io_strobe[4]),
		.inc_en     (io_strobe[6]),
		.cmd_data_q (cmd_data_q),
		.s0_mb_x    (s0_mb_x),
		.s0_mb_y    (s0_mb_y),
		.mb_busy    (mb_busy)
	);

	m2v_side_info u_side (
		.clk          (clk),
		.reset_n      (reset_n),
		.qs_en        (io_strobe[5]),
		.qm_en        (io_strobe[3]),
		.side_strobe  (side_strobe),
		.cmd_data_q   (cmd_data_q),
		.s0_data      (s0_data),
		.pict_valid   (pict_valid),
		.mvec_h_valid (mvec_h_valid),
		.mvec_v_valid (mvec_v_valid),
		.s0_valid     (s0_valid),
		.s0_mb_qscode (s0_mb_qscode),
		.qm_valid     (qm_valid),
		.qm_intra     (qm_intra),
		.qm_custom    (qm_custom),
		.qm_value     (qm_value)
	);

endmodule

//--- m2v_side_info.sv
// Side information and quantiser outputs
// Scale codes, quant-matrix load strobes and side-stage strobes with payload

`include "m2v_cfg.svh"

module m2v_side_info (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   qs_en,
	input  logic                   qm_en,
	input  logic [3:0]             side_strobe,
	input  m2v_cmd_pkg::cmd_data_t cmd_data_q,
	output m2v_cmd_pkg::cmd_data_t s0_data,
	output logic                   pict_valid,
	output logic                   mvec_h_valid,
	output logic                   mvec_v_valid,
	output logic                   s0_valid,
	output m2v_stage_pkg::qscode_t s0_mb_qscode,
	output logic                   qm_valid,
	output logic                   qm_intra,
	output logic                   qm_custom,
	output logic [7:0]             qm_value
);

	m2v_stage_pkg::qscode_t sl_qscode;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pict_valid   <= 1'b0;
			mvec_h_valid <= 1'b0;
			mvec_v_valid <= 1'b0;
			s0_valid     <= 1'b0;
			qm_valid     <= 1'b0;
			sl_qscode    <= '0;
			s0_mb_qscode <= '0;
		end else begin
			pict_valid   <= side_strobe[m2v_cmd_pkg::SS_PICT];
			mvec_h_valid <= side_strobe[m2v_cmd_pkg::SS_MVH];
			mvec_v_valid <= side_strobe[m2v_cmd_pkg::SS_MVV];
			s0_valid     <= side_strobe[m2v_cmd_pkg::SS_BLKV];
			qm_valid     <= qm_en;
			if (qs_en) begin
				if (cmd_data_q[m2v_cmd_pkg::QC_SLICE])
					sl_qscode <= cmd_data_q[`M2V_QS_WIDTH-1:0];
				// Copy takes the slice code from before this command
				if (cmd_data_q[m2v_cmd_pkg::QC_COPY])
					s0_mb_qscode <= sl_qscode;
				else if (!cmd_data_q[m2v_cmd_pkg::QC_SLICE])
					s0_mb_qscode <= cmd_data_q[`M2V_QS_WIDTH-1:0];
			end
		end
	end

	// Payload lines up with its strobe
	always_ff @(posedge clk) begin
		if (|side_strobe)
			s0_data <= cmd_data_q;
		if (qm_en) begin
			qm_intra  <= cmd_data_q[m2v_cmd_pkg::QM_INTRA];
			qm_custom <= cmd_data_q[m2v_cmd_pkg::QM_CUSTOM];
			qm_value  <= cmd_data_q[7:0];
		end
	end

endmodule

//--- m2v_mb_addr.sv
// Macroblock address tracker
// Adds increments to the column and wraps onto following rows, one row per
// cycle, holding off further commands while it does so

`include "m2v_cfg.svh"

module m2v_mb_addr (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   max_en,
	input  logic                   slice_en,
	input  logic                   inc_en,
	input  m2v_cmd_pkg::cmd_data_t cmd_data_q,
	output m2v_stage_pkg::mb_x_t   s0_mb_x,
	output m2v_stage_pkg::mb_y_t   s0_mb_y,
	output logic                   mb_busy
);

	localparam int XW = `M2V_MBX_WIDTH;
	localparam int YW = `M2V_MBY_WIDTH;

	// Spare top bit holds the column before it wraps
	logic [XW:0]          col;
	logic [XW:0]          row_len;
	logic                 over;
	m2v_stage_pkg::mb_x_t max_x;
	m2v_stage_pkg::mb_y_t row;

	assign row_len = {1'b0, max_x} + 1'b1;
	assign over    = col > {1'b0, max_x};

	// Busy from the increment itself until the column is back in range
	assign mb_busy = inc_en | over;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			max_x <= '0;
			col   <= '0;
			row   <= '0;
		end else begin
			if (max_en)
				max_x <= cmd_data_q[XW-1:0];
			if (slice_en) begin
				// Parked at the row end so the first step lands on the next row
				col <= {1'b0, max_x};
				row <= cmd_data_q[YW-1:0];
			end else if (inc_en) begin
				col <= col + {1'b0, cmd_data_q[XW-1:0]};
			end else if (over) begin
				col <= col - row_len;
				row <= row + 1'b1;
			end
		end
	end

	assign s0_mb_x = col[XW-1:0];
	assign s0_mb_y = row;

endmodule

//--- m2v_host_regs.sv
// Host control and status registers
// Interrupt flags, soft reset, picture counter, video info and block pulses,
// with readback over the two-word control port

`include "m2v_cfg.svh"

module m2v_host_regs (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      control_address,
	input  logic                      control_read,
	input  logic                      control_write,
	input  m2v_stage_pkg::host_word_t control_writedata,
	input  logic                      ctrl_en,
	input  logic                      video_en,
	input  m2v_cmd_pkg::cmd_data_t    cmd_data_q,
	output m2v_stage_pkg::host_word_t control_readdata,
	output logic                      control_readdatavalid,
	output logic                      irq,
	output logic                      softreset,
	output logic                      pre_block_start,
	output logic                      block_start,
	output logic                      block_end,
	output logic                      picture_complete
);

	logic                      addr_q;
	logic                      status_wr;
	logic                      pic_cmd;
	logic                      irq_seq;
	logic                      irq_pic;
	logic                      pause;
	logic                      error;
	m2v_stage_pkg::pic_count_t pictures;
	logic [9:0]                video_wd;
	logic [9:0]                video_ht;
	logic [3:0]                frate;
	m2v_stage_pkg::host_word_t status_word;
	m2v_stage_pkg::host_word_t video_word;

	assign status_wr = control_write & ~control_address;
	assign pic_cmd   = ctrl_en & cmd_data_q[m2v_cmd_pkg::CN_IRQ_PIC];

	//------------------------------------------------------------
	// Host readback, one cycle after the read
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			addr_q                <= 1'b0;
			control_readdatavalid <= 1'b0;
		end else begin
			addr_q                <= control_address;
			control_readdatavalid <= control_read;
		end
	end

	always_comb begin
		status_word = '0;
		status_word[m2v_stage_pkg::ST_PIC_MSB:m2v_stage_pkg::ST_PIC_LSB] = pictures;
		status_word[m2v_stage_pkg::ST_IRQ_SEQ] = irq_seq;
		status_word[m2v_stage_pkg::ST_IRQ_PIC] = irq_pic;
		status_word[m2v_stage_pkg::ST_PAUSE]   = pause;
		status_word[m2v_stage_pkg::ST_ERROR]   = error;
	end

	assign video_word       = {frate, 2'b00, video_ht, 6'd0, video_wd};
	assign control_readdata = addr_q ? video_word : status_word;

	//------------------------------------------------------------
	// Flags; a host write clears, a command sets
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			irq_seq <= 1'b0;
			irq_pic <= 1'b0;
			pause   <= 1'b0;
			error   <= 1'b0;
		end else begin
			if (status_wr && control_writedata[m2v_cmd_pkg::CN_IRQ_SEQ])
				irq_seq <= 1'b0;
			else if (ctrl_en && cmd_data_q[m2v_cmd_pkg::CN_IRQ_SEQ])
				irq_seq <= 1'b1;
			if (status_wr && control_writedata[m2v_cmd_pkg::CN_IRQ_PIC])
				irq_pic <= 1'b0;
			else if (pic_cmd)
				irq_pic <= 1'b1;
			// Picture end also pauses the stages
			if (status_wr && control_writedata[m2v_cmd_pkg::CN_PAUSE])
				pause <= 1'b0;
			else if (pic_cmd)
				pause <= 1'b1;
			if (status_wr && control_writedata[m2v_cmd_pkg::CN_ERROR])
				error <= 1'b0;
			else if (ctrl_en && cmd_data_q[m2v_cmd_pkg::CN_ERROR])
				error <= 1'b1;
		end
	end

	assign irq = irq_seq | irq_pic;

	//------------------------------------------------------------
	// Soft reset, picture counter and stage pulses
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			softreset        <= 1'(`M2V_SOFTRESET_INIT);
			pictures         <= '0;
			pre_block_start  <= 1'b0;
			block_start      <= 1'b0;
			block_end        <= 1'b0;
			picture_complete <= 1'b0;
		end else begin
			if (status_wr)
				softreset <= control_writedata[m2v_cmd_pkg::CN_SOFTRESET];
			if (softreset)
				pictures <= '0;
			else if (pic_cmd)
				pictures <= pictures + 1'b1;
			pre_block_start  <= ctrl_en & cmd_data_q[m2v_cmd_pkg::CN_BLK_START];
			block_start      <= pre_block_start;
			block_end        <= ctrl_en & cmd_data_q[m2v_cmd_pkg::CN_BLK_END];
			picture_complete <= pic_cmd;
		end
	end

	// Video basic info, each field under its own flag
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			video_wd <= '0;
			video_ht <= '0;
			frate    <= '0;
		end else if (video_en) begin
			if (cmd_data_q[m2v_cmd_pkg::VI_WIDTH])
				video_wd <= cmd_data_q[9:0];
			if (cmd_data_q[m2v_cmd_pkg::VI_HEIGHT])
				video_ht <= cmd_data_q[9:0];
			if (cmd_data_q[m2v_cmd_pkg::VI_FRATE])
				frate <= cmd_data_q[3:0];
		end
	end

endmodule

//--- m2v_cmd_decode.sv
// Command port decoder
// Accepts sequencer commands and turns each one into a one-cycle strobe

module m2v_cmd_decode (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   cmd_valid,
	input  m2v_cmd_pkg::cmd_sel_t  cmd_sel,
	input  m2v_cmd_pkg::cmd_data_t cmd_data,
	input  logic                   mb_busy,
	output logic                   cmd_ready,
	output logic [6:0]             io_strobe,
	output logic [3:0]             side_strobe,
	output m2v_cmd_pkg::cmd_data_t cmd_data_q
);

	logic       xfer;
	logic [6:0] io_dec;
	logic [3:0] side_dec;

	// Only the macroblock wrap stalls the sequencer
	assign cmd_ready = ~mb_busy;
	assign xfer      = cmd_valid & cmd_ready;

	// Strobe bit n belongs to I/O address n+1
	always_comb begin
		io_dec   = '0;
		side_dec = '0;
		if (cmd_sel[m2v_cmd_pkg::SEL_SIDE]) begin
			side_dec = cmd_sel[m2v_cmd_pkg::SEL_FLAG_LSB +: 4];
		end else begin
			case (m2v_cmd_pkg::io_addr_e'(cmd_sel[3:0]))
				m2v_cmd_pkg::IO_CONTROL:   io_dec[0] = 1'b1;
				m2v_cmd_pkg::IO_VIDEOINFO: io_dec[1] = 1'b1;
				m2v_cmd_pkg::IO_MAX_MBXY:  io_dec[2] = 1'b1;
				m2v_cmd_pkg::IO_QMATRIX:   io_dec[3] = 1'b1;
				m2v_cmd_pkg::IO_SLICEVERT: io_dec[4] = 1'b1;
				m2v_cmd_pkg::IO_QSCODE:    io_dec[5] = 1'b1;
				m2v_cmd_pkg::IO_MB_ADDR:   io_dec[6] = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			io_strobe   <= '0;
			side_strobe <= '0;
		end else begin
			io_strobe   <= xfer ? io_dec : '0;
			side_strobe <= xfer ? side_dec : '0;
		end
	end

	// Data word held until the next transfer
	always_ff @(posedge clk) begin
		if (xfer)
			cmd_data_q <= cmd_data;
	end

endmodule

//--- m2v_stage_pkg.sv
// MPEG-2 decode controller stage types
// Values handed to the decode stages and the host status word layout

`include "m2v_cfg.svh"

package m2v_stage_pkg;

	// Macroblock column and row
	typedef logic [`M2V_MBX_WIDTH-1:0] mb_x_t;
	typedef logic [`M2V_MBY_WIDTH-1:0] mb_y_t;

	typedef logic [`M2V_QS_WIDTH-1:0] qscode_t;
	typedef logic [`M2V_PIC_COUNT_WIDTH-1:0] pic_count_t;
	typedef logic [`M2V_HOST_DATA_WIDTH-1:0] host_word_t;

	//------------------------------------------------------------
	// Status word
	//------------------------------------------------------------
	localparam int ST_PIC_MSB = 31;
	localparam int ST_PIC_LSB = 24;
	localparam int ST_IRQ_SEQ = 3;
	localparam int ST_IRQ_PIC = 4;
	localparam int ST_PAUSE   = 5;
	localparam int ST_ERROR   = 6;

endpackage

//--- m2v_cmd_pkg.sv
// MPEG-2 decode controller command encodings
// Selector layout, I/O addresses and the data bit positions of each command

`include "m2v_cfg.svh"

package m2v_cmd_pkg;

	typedef logic [`M2V_CMD_DATA_WIDTH-1:0] cmd_data_t;

	// Low nibble is the I/O address, bit 8 marks side information
	typedef logic [`M2V_CMD_SEL_WIDTH-1:0] cmd_sel_t;

	typedef enum logic [3:0] {
		IO_CONTROL   = 4'd1,
		IO_VIDEOINFO = 4'd2,
		IO_MAX_MBXY  = 4'd3,
		IO_QMATRIX   = 4'd4,
		IO_SLICEVERT = 4'd5,
		IO_QSCODE    = 4'd6,
		IO_MB_ADDR   = 4'd7
	} io_addr_e;

	//------------------------------------------------------------
	// Selector fields
	//------------------------------------------------------------
	localparam int SEL_SIDE     = 8;
	localparam int SEL_FLAG_LSB = 4;

	// Side strobe order, bits 4..7 of the selector
	localparam int SS_PICT = 0;
	localparam int SS_MVH  = 1;
	localparam int SS_MVV  = 2;
	localparam int SS_BLKV = 3;

	//------------------------------------------------------------
	// Data bits, also used by the host status write
	//------------------------------------------------------------
	localparam int CN_BLK_START = 0;
	localparam int CN_BLK_END   = 2;
	localparam int CN_IRQ_SEQ   = 3;
	localparam int CN_IRQ_PIC   = 4;
	localparam int CN_PAUSE     = 5;
	localparam int CN_ERROR     = 6;
	localparam int CN_SOFTRESET = 7;

	localparam int VI_WIDTH  = 13;
	localparam int VI_HEIGHT = 14;
	localparam int VI_FRATE  = 15;

	localparam int QM_INTRA  = 8;
	localparam int QM_CUSTOM = 9;

	localparam int QC_SLICE = 5;
	localparam int QC_COPY  = 6;

endpackage

//--- m2v_cfg.svh
// MPEG-2 decode controller configuration
// Field widths and reset values shared by the packages and RTL

`ifndef M2V_CFG_SVH
`define M2V_CFG_SVH

//------------------------------------------------------------
// Macroblock position
//------------------------------------------------------------
`define M2V_MBX_WIDTH 6
`define M2V_MBY_WIDTH 5

//------------------------------------------------------------
// Command port
//------------------------------------------------------------
`define M2V_CMD_DATA_WIDTH 16
`define M2V_CMD_SEL_WIDTH 9

//------------------------------------------------------------
// Stage and host values
//------------------------------------------------------------
`define M2V_QS_WIDTH 5
`define M2V_PIC_COUNT_WIDTH 8
`define M2V_HOST_DATA_WIDTH 32
`define M2V_SOFTRESET_INIT 1

`endif
